/* hw/dispatch_settings.svh */
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// ========================================
// dispatch stage sizing
// ========================================

// reorder buffer depth, a power of two keeps index wrap cheap
`define ROB_ENTRIES 8
// rse slots per dispatch bundle
`define DISP_WIDTH 2
// simple alu and address generation unit counts
`define NSAU 2
`define NAGEN 2
// busy vector width, sau0 sau1 mul fcu agen0 agen1
`define NUNITS 6
// 1 makes each entry wait for its predecessor to finish
`define SERIALIZE 0

`endif

/* hw/rob_pkg.sv */
`include "dispatch_settings.svh"

package rob_pkg;

	// ========================================
	// reorder buffer contents
	// ========================================

	typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_idx_t;

	// functional unit class of a micro-op
	typedef enum logic [1:0] {
		OC_SAU,
		OC_MUL,
		OC_FCU,
		OC_MEM
	} op_class_e;

	// source operand as seen at allocation
	typedef struct packed {
		logic        valid;
		logic [7:0]  areg;
		logic [7:0]  ptag;
		logic [31:0] value;
	} rob_arg_t;

	// record handed over by the allocation handshake
	typedef struct packed {
		op_class_e  cls;
		logic       store;
		logic [7:0] uop;
		// predicate state, pred only means something once pred_v is set
		logic       pred_v;
		logic       pred;
		rob_arg_t   arg_a;
		rob_arg_t   arg_b;
	} rob_alloc_t;

	// one rob slot with its tracking bits
	typedef struct packed {
		logic       valid;
		logic       out;
		logic       done;
		rob_alloc_t op;
	} rob_entry_t;

endpackage

/* hw/issue_pkg.sv */
`include "dispatch_settings.svh"

package issue_pkg;

	import rob_pkg::*;

	// ========================================
	// reservation station side
	// ========================================

	typedef logic [2:0] unit_id_t;

	// first unit of each class, counted classes take base + n
	localparam unit_id_t UNIT_SAU0  = 3'd0;
	localparam unit_id_t UNIT_MUL   = 3'd2;
	localparam unit_id_t UNIT_FCU   = 3'd3;
	localparam unit_id_t UNIT_AGEN0 = 3'd4;

	// uop sent for predicated-off entries
	localparam logic [7:0] UOP_NOP = 8'h00;

	// register tag view of an operand word
	typedef struct packed {
		logic [15:0] pad;
		logic [7:0]  areg;
		logic [7:0]  ptag;
	} operand_tag_t;

	// value or tag, picked by the operand valid bit
	typedef union packed {
		logic [31:0]  value;
		operand_tag_t tag;
	} operand_u;

	typedef struct packed {
		logic     valid;
		operand_u word;
	} rse_arg_t;

	typedef struct packed {
		rob_idx_t   rndx;
		unit_id_t   unit;
		logic [7:0] uop;
		logic       nop;
		logic       store;
		rse_arg_t   arg_a;
		rse_arg_t   arg_b;
	} rse_t;

	// slot 0 always holds the oldest chosen entry
	typedef struct packed {
		logic [`DISP_WIDTH-1:0] slot_v;
		rse_t [`DISP_WIDTH-1:0] slot;
	} dispatch_bundle_t;

endpackage

/* hw/rob_table.sv */
`include "dispatch_settings.svh"

module rob_table
	import rob_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  logic                            alloc_req_i,
	input  rob_alloc_t                      alloc_entry_i,
	output logic                            alloc_ack_o,
	input  logic                            done_i,
	input  rob_idx_t                        done_idx_i,
	input  logic [`ROB_ENTRIES-1:0]         disp_mask_i,
	output rob_entry_t [`ROB_ENTRIES-1:0]   rob_o,
	output rob_idx_t                        head_o
);

	localparam int N = `ROB_ENTRIES;
	localparam int CW = $clog2(N) + 1;

	// payload, written once per allocation
	rob_alloc_t [N-1:0] op_q;
	// per-entry tracking bits
	logic [N-1:0] valid_q;
	logic [N-1:0] out_q;
	logic [N-1:0] done_q;
	rob_idx_t head_q;
	rob_idx_t tail_q;
	logic [CW-1:0] count_q;
	logic alloc_ack_q;
	logic full;
	logic alloc_go;
	logic retire_go;

	function automatic rob_idx_t next_idx(rob_idx_t i);
		return rob_idx_t'((int'(i) + 1) % N);
	endfunction

	assign full = (count_q == CW'(N));
	// take a new request only in the idle phase of the handshake
	assign alloc_go = alloc_req_i && !alloc_ack_q && !full;
	// oldest entry leaves once its unit reported completion
	assign retire_go = valid_q[head_q] && done_q[head_q];

	always_ff @(posedge clk) begin
		if (alloc_go) begin
			op_q[tail_q] <= alloc_entry_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
			out_q <= '0;
			done_q <= '0;
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
			alloc_ack_q <= 1'b0;
		end else begin
			// entries picked this cycle go out with the bundle capture
			out_q <= out_q | (disp_mask_i & valid_q);
			if (done_i && valid_q[done_idx_i]) begin
				done_q[done_idx_i] <= 1'b1;
			end
			if (retire_go) begin
				valid_q[head_q] <= 1'b0;
				head_q <= next_idx(head_q);
			end
			// tail never meets a retiring head since alloc needs a free slot
			if (alloc_go) begin
				valid_q[tail_q] <= 1'b1;
				out_q[tail_q] <= 1'b0;
				done_q[tail_q] <= 1'b0;
				tail_q <= next_idx(tail_q);
			end
			if (alloc_go && !retire_go) begin
				count_q <= count_q + 1'b1;
			end else if (!alloc_go && retire_go) begin
				count_q <= count_q - 1'b1;
			end
			// ack holds until req drops
			if (alloc_go) begin
				alloc_ack_q <= 1'b1;
			end else if (!alloc_req_i) begin
				alloc_ack_q <= 1'b0;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < N; i++) begin
			rob_o[i].valid = valid_q[i];
			rob_o[i].out = out_q[i];
			rob_o[i].done = done_q[i];
			rob_o[i].op = op_q[i];
		end
	end

	assign head_o = head_q;
	assign alloc_ack_o = alloc_ack_q;

endmodule

/* hw/instruction_dispatcher.sv */
`include "dispatch_settings.svh"

module instruction_dispatcher
	import rob_pkg::*;
	import issue_pkg::*;
(
	input  rob_entry_t [`ROB_ENTRIES-1:0] rob_i,
	input  rob_idx_t                      head_i,
	input  logic [`NUNITS-1:0]            busy_i,
	input  logic                          handoff_free_i,
	output logic [`ROB_ENTRIES-1:0]       disp_mask_o,
	output dispatch_bundle_t              bundle_o,
	output logic                          bundle_v_o
);

	localparam int N = `ROB_ENTRIES;

	// ========================================
	// rse entry build
	// ========================================

	// valid operands carry the value, others the tag view
	function automatic rse_arg_t build_arg(rob_arg_t a);
		rse_arg_t r;
		r.valid = a.valid;
		if (a.valid) begin
			r.word.value = a.value;
		end else begin
			r.word.tag.pad = '0;
			r.word.tag.areg = a.areg;
			r.word.tag.ptag = a.ptag;
		end
		return r;
	endfunction

	function automatic rse_t build_rse(rob_entry_t e, rob_idx_t idx, unit_id_t unit);
		rse_t r;
		r.rndx = idx;
		r.unit = unit;
		r.nop = !e.op.pred;
		if (r.nop) begin
			// predicated off, nothing to wait for
			r.uop = UOP_NOP;
			r.store = 1'b0;
			r.arg_a.valid = 1'b1;
			r.arg_a.word.value = '0;
			r.arg_b.valid = 1'b1;
			r.arg_b.word.value = '0;
		end else begin
			r.uop = e.op.uop;
			r.store = e.op.store;
			r.arg_a = build_arg(e.op.arg_a);
			r.arg_b = build_arg(e.op.arg_b);
		end
		return r;
	endfunction

	// ========================================
	// oldest-first scan
	// ========================================

	always_comb begin
		int taken;
		int limit;
		int cls_cnt [4];
		logic fc_pending;
		logic ready;
		rob_idx_t idx;
		rob_idx_t prev;
		op_class_e cls;
		unit_id_t base;
		unit_id_t unit;
		taken = 0;
		fc_pending = 1'b0;
		for (int c = 0; c < 4; c++) begin
			cls_cnt[c] = 0;
		end
		disp_mask_o = '0;
		bundle_o = '0;
		for (int k = 0; k < N; k++) begin
			idx = rob_idx_t'((int'(head_i) + k) % N);
			prev = rob_idx_t'((int'(idx) + N - 1) % N);
			cls = rob_i[idx].op.cls;
			ready = rob_i[idx].valid && !rob_i[idx].out && !rob_i[idx].done &&
				rob_i[idx].op.pred_v &&
				(!rob_i[idx].op.store || !fc_pending) &&
				(`SERIALIZE == 0 || rob_i[prev].done || !rob_i[prev].valid) &&
				handoff_free_i && (taken < `DISP_WIDTH);
			// unit pool of the class
			case (cls)
				OC_SAU: begin
					base = UNIT_SAU0;
					limit = `NSAU;
				end
				OC_MUL: begin
					base = UNIT_MUL;
					limit = 1;
				end
				OC_FCU: begin
					base = UNIT_FCU;
					limit = 1;
				end
				default: begin
					base = UNIT_AGEN0;
					limit = `NAGEN;
				end
			endcase
			// n-th pick of a class may only use the n-th unit
			unit = unit_id_t'(int'(base) + cls_cnt[cls]);
			if (ready && (cls_cnt[cls] < limit) && !busy_i[unit]) begin
				bundle_o.slot[taken] = build_rse(rob_i[idx], idx, unit);
				bundle_o.slot_v[taken] = 1'b1;
				disp_mask_o[idx] = 1'b1;
				cls_cnt[cls] = cls_cnt[cls] + 1;
				taken = taken + 1;
			end
			// younger stores wait behind an unfinished flow-control op
			if (rob_i[idx].valid && cls == OC_FCU && !rob_i[idx].done) begin
				fc_pending = 1'b1;
			end
		end
		bundle_v_o = |bundle_o.slot_v;
	end

endmodule

/* hw/dispatch_handoff.sv */
module dispatch_handoff
	import issue_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n_i,
	input  dispatch_bundle_t bundle_i,
	input  logic             bundle_v_i,
	output logic             handoff_free_o,
	output logic             rse_req_o,
	output dispatch_bundle_t rse_bundle_o,
	input  logic             rse_ack_i
);

	// four-phase toward the reservation stations
	typedef enum logic [1:0] {
		HS_FREE,
		HS_REQ,
		HS_ACK_LOW
	} hs_state_e;

	hs_state_e state_q;
	hs_state_e state_d;
	dispatch_bundle_t bundle_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			HS_FREE: if (bundle_v_i) state_d = HS_REQ;
			HS_REQ: if (rse_ack_i) state_d = HS_ACK_LOW;
			HS_ACK_LOW: if (!rse_ack_i) state_d = HS_FREE;
			default: state_d = HS_FREE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= HS_FREE;
		end else begin
			state_q <= state_d;
		end
	end

	// dispatcher only offers while free, so valid alone loads
	always_ff @(posedge clk) begin
		if (bundle_v_i) begin
			bundle_q <= bundle_i;
		end
	end

	assign handoff_free_o = (state_q == HS_FREE);
	assign rse_req_o = (state_q == HS_REQ);
	assign rse_bundle_o = bundle_q;

endmodule

/* hw/dispatch_core.sv */
`include "dispatch_settings.svh"

module dispatch_core
	import rob_pkg::*;
	import issue_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               alloc_req_i,
	input  rob_alloc_t         alloc_entry_i,
	output logic               alloc_ack_o,
	input  logic               done_i,
	input  rob_idx_t           done_idx_i,
	input  logic [`NUNITS-1:0] busy_i,
	output logic               rse_req_o,
	output dispatch_bundle_t   rse_bundle_o,
	input  logic               rse_ack_i
);

	// table to dispatcher
	rob_entry_t [`ROB_ENTRIES-1:0] rob;
	rob_idx_t head;
	// dispatcher to table and handoff
	logic [`ROB_ENTRIES-1:0] disp_mask;
	dispatch_bundle_t bundle;
	logic bundle_v;
	logic handoff_free;

	rob_table u_rob_table (
		.clk(clk), .rst_n_i(rst_n_i),
		.alloc_req_i(alloc_req_i), .alloc_entry_i(alloc_entry_i), .alloc_ack_o(alloc_ack_o),
		.done_i(done_i), .done_idx_i(done_idx_i), .disp_mask_i(disp_mask),
		.rob_o(rob), .head_o(head)
	);

	instruction_dispatcher u_dispatcher (
		.rob_i(rob), .head_i(head), .busy_i(busy_i), .handoff_free_i(handoff_free),
		.disp_mask_o(disp_mask), .bundle_o(bundle), .bundle_v_o(bundle_v)
	);

	dispatch_handoff u_handoff (
		.clk(clk), .rst_n_i(rst_n_i), .bundle_i(bundle), .bundle_v_i(bundle_v),
		.handoff_free_o(handoff_free), .rse_req_o(rse_req_o),
		.rse_bundle_o(rse_bundle_o), .rse_ack_i(rse_ack_i)
	);

endmodule

/* sim/dispatch_checker.sv */
`include "dispatch_settings.svh"

module dispatch_checker
	import issue_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             rse_req_i,
	input  dispatch_bundle_t rse_bundle_i,
	output int               err_cnt_o,
	output int               left_o
);

	// one expected reservation-station entry
	typedef struct packed {
		logic [2:0]  rndx;
		logic [2:0]  unit;
		logic        nop;
		logic [31:0] word_a;
		logic [31:0] word_b;
	} exp_rec_t;

	exp_rec_t exp_q [$];
	int exp_total = 0;
	int exp_pos = 0;
	int load_err = 0;
	int cmp_err = 0;
	logic req_seen = 1'b0;

	// ========================================
	// expected records from the golden file
	// ========================================

	initial begin
		int fd;
		int rc;
		string line;
		logic [31:0] f [5];
		exp_rec_t rec;
		fd = $fopen("sim/dispatch_golden.txt", "r");
		if (fd == 0) begin
			$display("checker could not open sim/dispatch_golden.txt");
			load_err = 1;
		end else begin
			while (!$feof(fd)) begin
				rc = $fgets(line, fd);
				// only E lines belong here
				if (rc > 0 && line.getc(0) == "E") begin
					rc = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4]);
					if (rc != 5) begin
						$display("malformed expected record: %s", line);
						load_err = load_err + 1;
					end else begin
						rec.rndx = f[0][2:0];
						rec.unit = f[1][2:0];
						rec.nop = f[2][0];
						rec.word_a = f[3];
						rec.word_b = f[4];
						exp_q.push_back(rec);
					end
				end
			end
			$fclose(fd);
		end
		exp_total = exp_q.size();
	end

	// ========================================
	// bundle compare
	// ========================================

	task automatic check_slot(input int s, input rse_t got);
		exp_rec_t e;
		if (exp_pos >= exp_total) begin
			$display("extra dispatch of rob index %0d in slot %0d, no expected record left",
				got.rndx, s);
			cmp_err = cmp_err + 1;
			return;
		end
		e = exp_q[exp_pos];
		exp_pos = exp_pos + 1;
		if (got.rndx != e.rndx || got.unit != e.unit || got.nop != e.nop ||
			got.arg_a.word.value != e.word_a || got.arg_b.word.value != e.word_b) begin
			$display("ERR %0t: slot %0d got rob %0d unit %0d nop %0b a %h b %h", $time, s,
				got.rndx, got.unit, got.nop, got.arg_a.word.value, got.arg_b.word.value);
			$display("ERR %0t: slot %0d expected rob %0d unit %0d nop %0b a %h b %h", $time, s,
				e.rndx, e.unit, e.nop, e.word_a, e.word_b);
			cmp_err = cmp_err + 1;
		end
		// a nop has nothing left to wait for
		if (got.nop && !(got.arg_a.valid && got.arg_b.valid)) begin
			$display("ERR %0t: nop for rob %0d has an operand not marked valid",
				$time, got.rndx);
			cmp_err = cmp_err + 1;
		end
	endtask

	// bundle is stable while req is high, so look once after it rises
	always @(negedge clk) begin
		if (!rst_n_i) begin
			req_seen = 1'b0;
		end else begin
			if (rse_req_i && !req_seen) begin
				for (int s = 0; s < `DISP_WIDTH; s++) begin
					if (rse_bundle_i.slot_v[s]) begin
						check_slot(s, rse_bundle_i.slot[s]);
					end
				end
			end
			req_seen = rse_req_i;
		end
	end

	assign err_cnt_o = load_err + cmp_err;
	assign left_o = exp_total - exp_pos;

endmodule

/* sim/dispatch_core_sva.sv */
`include "dispatch_settings.svh"

module dispatch_core_sva
	import issue_pkg::*;
(
	input logic               clk,
	input logic               rst_n_i,
	input logic               alloc_req_i,
	input logic               alloc_ack_i,
	input logic [`NUNITS-1:0] busy_i,
	input logic               bundle_v_i,
	input dispatch_bundle_t   bundle_i,
	input logic               rse_req_i,
	input logic               rse_ack_i,
	input dispatch_bundle_t   rse_bundle_i
);

	// failed assertions so far
	int fail_cnt = 0;

	// request holds with the same bundle until the stations answer
	req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		rse_req_i && !rse_ack_i |=> rse_req_i && $stable(rse_bundle_i))
		else begin
			$error("rse_req_o dropped or bundle changed before ack");
			fail_cnt = fail_cnt + 1;
		end

	// ack only ever answers a request
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		!alloc_req_i && !alloc_ack_i |=> !alloc_ack_i)
		else begin
			$error("alloc_ack_o rose without alloc_req_i");
			fail_cnt = fail_cnt + 1;
		end

	no_dup_index: assert property (@(posedge clk) disable iff (!rst_n_i)
		rse_req_i && rse_bundle_i.slot_v[0] && rse_bundle_i.slot_v[1] |->
		rse_bundle_i.slot[0].rndx != rse_bundle_i.slot[1].rndx)
		else begin
			$error("same rob index in both slots of one bundle");
			fail_cnt = fail_cnt + 1;
		end

	// unit of each taken slot must be idle in the capture cycle
	slot0_unit_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
		bundle_v_i && bundle_i.slot_v[0] |-> !busy_i[bundle_i.slot[0].unit])
		else begin
			$error("slot 0 captured on a busy unit");
			fail_cnt = fail_cnt + 1;
		end

	slot1_unit_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
		bundle_v_i && bundle_i.slot_v[1] |-> !busy_i[bundle_i.slot[1].unit])
		else begin
			$error("slot 1 captured on a busy unit");
			fail_cnt = fail_cnt + 1;
		end

endmodule

bind dispatch_core dispatch_core_sva u_sva (
	.clk(clk), .rst_n_i(rst_n_i),
	.alloc_req_i(alloc_req_i), .alloc_ack_i(alloc_ack_o),
	.busy_i(busy_i), .bundle_v_i(bundle_v), .bundle_i(bundle),
	.rse_req_i(rse_req_o), .rse_ack_i(rse_ack_i), .rse_bundle_i(rse_bundle_o)
);

/* sim/dispatch_core_tb.sv */
`include "dispatch_settings.svh"

module dispatch_core_tb
	import rob_pkg::*;
	import issue_pkg::*;
();

	logic clk = 1'b0;
	logic rst_n;
	logic alloc_req;
	rob_alloc_t alloc_entry;
	logic alloc_ack;
	logic done;
	rob_idx_t done_idx;
	logic [`NUNITS-1:0] busy;
	logic rse_req;
	dispatch_bundle_t rse_bundle;
	logic rse_ack;

	string lines [$];
	int line_cnt = 0;
	logic loaded = 1'b0;
	int tb_err = 0;
	int chk_err;
	int chk_left;

	always #5 clk = ~clk;

	dispatch_core UUT (
		.clk(clk), .rst_n_i(rst_n),
		.alloc_req_i(alloc_req), .alloc_entry_i(alloc_entry), .alloc_ack_o(alloc_ack),
		.done_i(done), .done_idx_i(done_idx), .busy_i(busy),
		.rse_req_o(rse_req), .rse_bundle_o(rse_bundle), .rse_ack_i(rse_ack)
	);

	dispatch_checker u_checker (
		.clk(clk), .rst_n_i(rst_n), .rse_req_i(rse_req), .rse_bundle_i(rse_bundle),
		.err_cnt_o(chk_err), .left_o(chk_left)
	);

	// ========================================
	// stimulus tasks driving on falling edges
	// ========================================

	// four-phase allocation where ack may wait while the rob is full
	task automatic alloc_op(input rob_alloc_t e);
		@(negedge clk);
		alloc_entry = e;
		alloc_req = 1'b1;
		while (!alloc_ack) begin
			@(negedge clk);
		end
		alloc_req = 1'b0;
		while (alloc_ack) begin
			@(negedge clk);
		end
	endtask

	task automatic set_busy(input logic [`NUNITS-1:0] v);
		@(negedge clk);
		busy = v;
	endtask

	task automatic complete_entry(input rob_idx_t idx);
		@(negedge clk);
		done = 1'b1;
		done_idx = idx;
		@(negedge clk);
		done = 1'b0;
	endtask

	// handoff quiet for 10 cycles in a row
	task automatic drain_idle();
		int idle;
		idle = 0;
		while (idle < 10) begin
			@(negedge clk);
			if (!rse_req && !rse_ack) begin
				idle = idle + 1;
			end else begin
				idle = 0;
			end
		end
	endtask

	task automatic run_line(input string line);
		logic [31:0] f [13];
		logic [7:0] cmd;
		int rc;
		rob_alloc_t e;
		if (line.len() < 2) begin
			return;
		end
		cmd = line.getc(0);
		case (cmd)
			"A": begin
				rc = $sscanf(line.substr(1, line.len() - 1),
					"%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
					f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
				if (rc != 13) begin
					$display("malformed alloc line: %s", line);
					tb_err = tb_err + 1;
				end else begin
					e = '0;
					e.cls = op_class_e'(f[0][1:0]);
					e.store = f[1][0];
					e.uop = f[2][7:0];
					e.pred_v = f[3][0];
					e.pred = f[4][0];
					e.arg_a.valid = f[5][0];
					e.arg_a.areg = f[6][7:0];
					e.arg_a.ptag = f[7][7:0];
					e.arg_a.value = f[8];
					e.arg_b.valid = f[9][0];
					e.arg_b.areg = f[10][7:0];
					e.arg_b.ptag = f[11][7:0];
					e.arg_b.value = f[12];
					alloc_op(e);
				end
			end
			"B": begin
				rc = $sscanf(line.substr(1, line.len() - 1), "%h", f[0]);
				if (rc != 1) begin
					$display("malformed busy line: %s", line);
					tb_err = tb_err + 1;
				end else begin
					set_busy(f[0][`NUNITS-1:0]);
				end
			end
			"C": begin
				rc = $sscanf(line.substr(1, line.len() - 1), "%h", f[0]);
				if (rc != 1) begin
					$display("malformed completion line: %s", line);
					tb_err = tb_err + 1;
				end else begin
					complete_entry(f[0][2:0]);
				end
			end
			"D": drain_idle();
			// comment lines and the E lines that the checker reads itself
			default: begin
			end
		endcase
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		int fd;
		string line;
		rst_n = 1'b0;
		alloc_req = 1'b0;
		alloc_entry = '0;
		done = 1'b0;
		done_idx = '0;
		busy = '0;
		fd = $fopen("sim/dispatch_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/dispatch_golden.txt");
			tb_err = tb_err + 1;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0) begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		line_cnt = lines.size();
		loaded = 1'b1;
		repeat (2) @(negedge clk);
		// both handshakes idle out of reset
		if (alloc_ack !== 1'b0 || rse_req !== 1'b0) begin
			$display("ERR %0t: in reset alloc_ack %b rse_req %b, expected both low",
				$time, alloc_ack, rse_req);
			tb_err = tb_err + 1;
		end
		rst_n = 1'b1;
		foreach (lines[i]) begin
			run_line(lines[i]);
		end
		drain_idle();
		if (chk_left > 0) begin
			$display("%0d expected dispatch records were never delivered", chk_left);
		end
		$display("summary: %0d compare errors, %0d missing records, %0d assertion failures, %0d testbench errors",
			chk_err, chk_left, UUT.u_sva.fail_cnt, tb_err);
		if (chk_err == 0 && chk_left == 0 && UUT.u_sva.fail_cnt == 0 && tb_err == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// reservation-station side answering after a random 0 to 3 cycle delay
	initial begin
		int dly;
		void'($urandom(72));
		rse_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (rse_req) begin
				dly = int'($urandom % 4);
				repeat (dly) @(negedge clk);
				rse_ack = 1'b1;
				while (rse_req) begin
					@(negedge clk);
				end
				rse_ack = 1'b0;
			end
		end
	end

	// 200 cycles for each golden line
	initial begin
		wait (loaded);
		repeat ((line_cnt + 1) * 200) @(posedge clk);
		$display("watchdog expired after %0d cycles, run did not finish", (line_cnt + 1) * 200);
		$display("Test failures found");
		$finish;
	end

endmodule

/* sim/dispatch_golden.txt */
# A cls store uop pv pred av areg ptag aval bv breg btag bval (hex, cls 0 sau 1 mul 2 fcu 3 mem)
# B busy, C rob index, D drain, E rndx unit nop aword bword (expected dispatch order)
# phase 1: four sau ops held back, then released together
B 3f
A 0 0 01 1 1 1 01 11 000000a0 1 02 12 000000b0
A 0 0 02 1 1 1 01 11 000000a1 1 02 12 000000b1
A 0 0 03 1 1 1 01 11 000000a2 1 02 12 000000b2
A 0 0 04 1 1 1 01 11 000000a3 1 02 12 000000b3
B 00
D
E 0 0 0 000000a0 000000b0
E 1 1 0 000000a1 000000b1
E 2 0 0 000000a2 000000b2
E 3 1 0 000000a3 000000b3
C 0
C 1
C 2
C 3
# phase 2: only one multiplier, sau joins the second mul
B 3f
A 1 0 10 1 1 1 03 13 00000100 1 04 14 00000200
A 1 0 11 1 1 1 03 13 00000101 1 04 14 00000201
A 0 0 12 1 1 1 05 15 00000102 1 06 16 00000202
B 03
B 00
D
E 4 2 0 00000100 00000200
E 5 2 0 00000101 00000201
E 6 0 0 00000102 00000202
C 4
C 5
C 6
# phase 3: mem waits for agen0, younger sau passes it
B 10
A 3 0 20 1 1 1 07 17 00000300 1 08 18 00000400
A 0 0 21 1 1 1 09 19 00000301 1 0a 1a 00000401
D
E 0 0 0 00000301 00000401
B 00
D
E 7 4 0 00000300 00000400
C 7
C 0
# phase 4: store waits behind an unfinished fcu op
A 2 0 30 1 1 1 0b 1b 00000030 1 0c 1c 00000031
A 3 1 31 1 1 1 0d 1d 00001000 0 0e 1e 00000000
D
E 1 3 0 00000030 00000031
C 1
D
E 2 4 0 00001000 00000e1e
C 2
# phase 5: predicated off op and tag operands
A 0 0 40 1 0 0 0f 1f 00000000 0 10 20 00000000
A 0 0 41 1 1 1 11 21 0000abcd 0 12 22 00000000
D
E 3 0 1 00000000 00000000
E 4 0 0 0000abcd 00001222
C 3
C 4
# phase 6: stream across the index wrap
B 3f
A 0 0 50 1 1 1 13 23 00000500 1 14 24 00000600
A 0 0 51 1 1 1 13 23 00000501 1 14 24 00000601
A 0 0 52 1 1 0 13 23 00000000 1 14 24 00000602
A 0 0 53 1 1 1 13 23 00000503 0 14 24 00000000
A 0 0 54 1 1 1 13 23 00000504 1 14 24 00000604
A 0 0 55 1 1 1 13 23 00000505 1 14 24 00000605
B 00
D
E 5 0 0 00000500 00000600
E 6 1 0 00000501 00000601
E 7 0 0 00001323 00000602
E 0 1 0 00000503 00001424
E 1 0 0 00000504 00000604
E 2 1 0 00000505 00000605

/* dispatch_core.f */
+incdir+hw
hw/rob_pkg.sv
hw/issue_pkg.sv
hw/rob_table.sv
hw/instruction_dispatcher.sv
hw/dispatch_handoff.sv
hw/dispatch_core.sv
sim/dispatch_checker.sv
sim/dispatch_core_sva.sv
sim/dispatch_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = dispatch_core_tb
FILELIST  = dispatch_core.f
OBJDIR    = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
